// File: verilog/lpif_cfg.svh
// Link widths, PHY channel layout and strobe period macros
`ifndef LPIF_CFG_SVH
`define LPIF_CFG_SVH

//////////////////////////////////////////////////////////////////////
// User side

`define LPIF_DATA_W      64
`define LPIF_CRC_W       8
`define LPIF_WORD_W      88

//////////////////////////////////////////////////////////////////////
// PHY side

`define LPIF_CHAN_N      4
`define LPIF_PHY_W       24
// Payload bits per channel
`define LPIF_LANE_W      22
// In-band bits, channel 0 only
`define LPIF_STB_BIT     23
`define LPIF_MRK_BIT     22

// Strobe repeats every this many words
`define LPIF_STB_PERIOD  8
`define LPIF_CNT_W       32

`endif

// File: verilog/lpif_pkg.sv
// Link word union and user field struct
`include "lpif_cfg.svh"

`default_nettype none

package lpif_pkg;

  //////////////////////////////////////////////////////////////////////
  // User fields, msb first

  typedef struct packed {
    // Fill up to the link word width
    logic [`LPIF_WORD_W-`LPIF_DATA_W-`LPIF_CRC_W-10:0] pad;
    logic [3:0]                                      state;
    logic [1:0]                                      protid;
    logic [`LPIF_DATA_W-1:0]                         data;
    logic                                            dvalid;
    logic [`LPIF_CRC_W-1:0]                          crc;
    logic                                            crc_valid;
    logic                                            valid;
  } lpif_fields_t;

  //////////////////////////////////////////////////////////////////////
  // One link word, seen as lanes or as fields

  typedef union packed {
    // Sliced into PHY lanes
    logic [`LPIF_WORD_W-1:0] raw;
    // Read and written by the user mapping
    lpif_fields_t            fields;
  } lpif_word_u;

endpackage

`default_nettype wire

// File: verilog/lpif_auto_sync.sv
// Online delay counters and in-band strobe/marker generation
`timescale 1ns/100ps
`include "lpif_cfg.svh"

`default_nettype none

module lpif_auto_sync (
  input  logic       clk_wr,
  input  logic       rst,
  input  logic       tx_online,
  input  logic       rx_online,
  input  logic [7:0] delay_x_value,
  input  logic [7:0] delay_xz_value,
  output logic       tx_online_delay,
  output logic       rx_online_delay,
  output logic       tx_stb_bit,
  output logic       tx_mrk_bit
);

  localparam int STB_CNT_W = $clog2(`LPIF_STB_PERIOD);

  // Index 0 is the tx side, index 1 the rx side
  logic       online_in  [2];
  logic [7:0] delay_val  [2];
  logic       online_q   [2];
  logic       online_nxt [2];
  logic [8:0] hold_cnt   [2];

  logic [STB_CNT_W-1:0] word_cnt;

  assign online_in[0] = tx_online;
  assign online_in[1] = rx_online;
  assign delay_val[0] = delay_xz_value;
  assign delay_val[1] = delay_x_value;

  //////////////////////////////////////////////////////////////////////
  // Online hold-off

  for (genvar i = 0; i < 2; i++) begin : g_hold
    // Level comes up once the hold count has run down to zero
    assign online_nxt[i] = online_in[i] & (online_q[i] | (hold_cnt[i] == 9'd0));

    always_ff @(posedge clk_wr) begin
      if (rst) begin
        online_q[i] <= 1'b0;
        hold_cnt[i] <= 9'd0;
      end else begin
        online_q[i] <= online_nxt[i];
        // Reloaded while offline, so every return waits the full delay
        if (!online_in[i]) begin
          hold_cnt[i] <= {1'b0, delay_val[i]} + 9'd1;
        end else if (hold_cnt[i] != 9'd0) begin
          hold_cnt[i] <= hold_cnt[i] - 9'd1;
        end
      end
    end
  end

  assign tx_online_delay = online_q[0];
  assign rx_online_delay = online_q[1];

  //////////////////////////////////////////////////////////////////////
  // Strobe and marker

  // Bits line up with the word on the wire in the same cycle
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      word_cnt   <= '0;
      tx_stb_bit <= 1'b0;
      tx_mrk_bit <= 1'b0;
    end else if (!online_nxt[0]) begin
      word_cnt   <= '0;
      tx_stb_bit <= 1'b0;
      tx_mrk_bit <= 1'b0;
    end else if (!online_q[0]) begin
      // First online word
      word_cnt   <= '0;
      tx_stb_bit <= 1'b1;
      tx_mrk_bit <= 1'b1;
    end else begin
      tx_mrk_bit <= ~tx_mrk_bit;
      if (word_cnt == STB_CNT_W'(`LPIF_STB_PERIOD - 1)) begin
        word_cnt   <= '0;
        tx_stb_bit <= 1'b1;
      end else begin
        word_cnt   <= word_cnt + 1'b1;
        tx_stb_bit <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/lpif_name.sv
// User field mapping into and out of the link word
`timescale 1ns/100ps
`include "lpif_cfg.svh"

`default_nettype none

module lpif_name import lpif_pkg::*; (
  // Downstream fields
  input  logic [3:0]              dstrm_state,
  input  logic [1:0]              dstrm_protid,
  input  logic [`LPIF_DATA_W-1:0] dstrm_data,
  input  logic                    dstrm_dvalid,
  input  logic [`LPIF_CRC_W-1:0]  dstrm_crc,
  input  logic                    dstrm_crc_valid,
  input  logic                    dstrm_valid,

  // Received link word
  input  lpif_word_u              rx_word,

  // Link word to send
  output lpif_word_u              tx_word,

  // Upstream fields
  output logic [3:0]              ustrm_state,
  output logic [1:0]              ustrm_protid,
  output logic [`LPIF_DATA_W-1:0] ustrm_data,
  output logic                    ustrm_dvalid,
  output logic [`LPIF_CRC_W-1:0]  ustrm_crc,
  output logic                    ustrm_crc_valid,
  output logic                    ustrm_valid_raw
);

  //////////////////////////////////////////////////////////////////////
  // Downstream packing

  always_comb begin
    tx_word.fields.pad       = '0;
    tx_word.fields.state     = dstrm_state;
    tx_word.fields.protid    = dstrm_protid;
    tx_word.fields.data      = dstrm_data;
    tx_word.fields.dvalid    = dstrm_dvalid;
    tx_word.fields.crc       = dstrm_crc;
    tx_word.fields.crc_valid = dstrm_crc_valid;
    tx_word.fields.valid     = dstrm_valid;
  end

  //////////////////////////////////////////////////////////////////////
  // Upstream unpacking

  // Pad is dropped on the way back
  assign ustrm_state     = rx_word.fields.state;
  assign ustrm_protid    = rx_word.fields.protid;
  assign ustrm_data      = rx_word.fields.data;
  assign ustrm_dvalid    = rx_word.fields.dvalid;
  assign ustrm_crc       = rx_word.fields.crc;
  assign ustrm_crc_valid = rx_word.fields.crc_valid;
  // Gated by rx online level in the destripe block
  assign ustrm_valid_raw = rx_word.fields.valid;

endmodule

`default_nettype wire

// File: verilog/lpif_tx_stripe.sv
// Transmit striping of the link word over the PHY channels
`timescale 1ns/100ps
`include "lpif_cfg.svh"

`default_nettype none

module lpif_tx_stripe import lpif_pkg::*; (
  input  logic                   clk_wr,
  input  logic                   rst,
  input  lpif_word_u             tx_word,
  input  logic                   tx_online_delay,
  input  logic                   tx_stb_bit,
  input  logic                   tx_mrk_bit,
  output logic [`LPIF_PHY_W-1:0] tx_phy0,
  output logic [`LPIF_PHY_W-1:0] tx_phy1,
  output logic [`LPIF_PHY_W-1:0] tx_phy2,
  output logic [`LPIF_PHY_W-1:0] tx_phy3,
  output logic [`LPIF_CNT_W-1:0] tx_downstream_debug_status
);

  localparam int CTRL_W = `LPIF_PHY_W - `LPIF_LANE_W;

  logic [`LPIF_LANE_W-1:0] lane_q [`LPIF_CHAN_N];
  logic [`LPIF_PHY_W-1:0]  phy_d  [`LPIF_CHAN_N];

  //////////////////////////////////////////////////////////////////////
  // Lane registers

  // Lane k goes to channel k
  always_ff @(posedge clk_wr) begin
    for (int k = 0; k < `LPIF_CHAN_N; k++) begin
      lane_q[k] <= tx_word.raw[k*`LPIF_LANE_W +: `LPIF_LANE_W];
    end
  end

  // Strobe and marker ride on channel 0 only
  for (genvar k = 0; k < `LPIF_CHAN_N; k++) begin : g_chan
    if (k == 0) begin : g_ctrl
      assign phy_d[k] = {tx_stb_bit, tx_mrk_bit, lane_q[k]};
    end else begin : g_data
      assign phy_d[k] = {{CTRL_W{1'b0}}, lane_q[k]};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // PHY outputs

  // Quiet wire until the link is online
  assign tx_phy0 = tx_online_delay ? phy_d[0] : '0;
  assign tx_phy1 = tx_online_delay ? phy_d[1] : '0;
  assign tx_phy2 = tx_online_delay ? phy_d[2] : '0;
  assign tx_phy3 = tx_online_delay ? phy_d[3] : '0;

  // Words sent
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_downstream_debug_status <= '0;
    end else if (tx_online_delay) begin
      tx_downstream_debug_status <= tx_downstream_debug_status + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/lpif_rx_destripe.sv
// Receive destriping, valid gating and marker alternation check
`timescale 1ns/100ps
`include "lpif_cfg.svh"

`default_nettype none

module lpif_rx_destripe import lpif_pkg::*; (
  input  logic                   clk_wr,
  input  logic                   rst,
  input  logic [`LPIF_PHY_W-1:0] rx_phy0,
  input  logic [`LPIF_PHY_W-1:0] rx_phy1,
  input  logic [`LPIF_PHY_W-1:0] rx_phy2,
  input  logic [`LPIF_PHY_W-1:0] rx_phy3,
  input  logic                   rx_online_delay,
  input  logic                   ustrm_valid_raw,
  output lpif_word_u             rx_word,
  output logic                   ustrm_valid,
  output logic [`LPIF_CNT_W-1:0] rx_upstream_debug_status
);

  logic [`LPIF_PHY_W-1:0] phy_in [`LPIF_CHAN_N];
  logic                   rx_mrk;
  logic                   mrk_synced;
  logic                   mrk_expect;

  assign phy_in[0] = rx_phy0;
  assign phy_in[1] = rx_phy1;
  assign phy_in[2] = rx_phy2;
  assign phy_in[3] = rx_phy3;

  //////////////////////////////////////////////////////////////////////
  // Word rebuild

  // Payload only, control bits stay behind
  always_ff @(posedge clk_wr) begin
    for (int k = 0; k < `LPIF_CHAN_N; k++) begin
      rx_word.raw[k*`LPIF_LANE_W +: `LPIF_LANE_W] <= phy_in[k][`LPIF_LANE_W-1:0];
    end
  end

  // Other fields pass through, valid does not
  assign ustrm_valid = rx_online_delay & ustrm_valid_raw;

  //////////////////////////////////////////////////////////////////////
  // Marker check

  assign rx_mrk = rx_phy0[`LPIF_MRK_BIT];

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      mrk_synced               <= 1'b0;
      mrk_expect               <= 1'b0;
      rx_upstream_debug_status <= '0;
    end else if (!rx_online_delay) begin
      // Lost sync, error count is kept
      mrk_synced <= 1'b0;
      mrk_expect <= 1'b0;
    end else if (!mrk_synced) begin
      // Lock on first marker seen high
      if (rx_mrk) begin
        mrk_synced <= 1'b1;
        mrk_expect <= 1'b0;
      end
    end else begin
      // Sequence runs on after a miss
      mrk_expect <= ~mrk_expect;
      if (rx_mrk != mrk_expect) begin
        rx_upstream_debug_status <= rx_upstream_debug_status + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/lpif_top.sv
// Link endpoint top level
`timescale 1ns/100ps
`include "lpif_cfg.svh"

`default_nettype none

module lpif_top import lpif_pkg::*; (
  input  logic                    clk_wr,
  input  logic                    rst,
  input  logic                    tx_online,
  input  logic                    rx_online,

  // PHY
  output logic [`LPIF_PHY_W-1:0]  tx_phy0,
  output logic [`LPIF_PHY_W-1:0]  tx_phy1,
  output logic [`LPIF_PHY_W-1:0]  tx_phy2,
  output logic [`LPIF_PHY_W-1:0]  tx_phy3,
  input  logic [`LPIF_PHY_W-1:0]  rx_phy0,
  input  logic [`LPIF_PHY_W-1:0]  rx_phy1,
  input  logic [`LPIF_PHY_W-1:0]  rx_phy2,
  input  logic [`LPIF_PHY_W-1:0]  rx_phy3,

  // Downstream
  input  logic [3:0]              dstrm_state,
  input  logic [1:0]              dstrm_protid,
  input  logic [`LPIF_DATA_W-1:0] dstrm_data,
  input  logic                    dstrm_dvalid,
  input  logic [`LPIF_CRC_W-1:0]  dstrm_crc,
  input  logic                    dstrm_crc_valid,
  input  logic                    dstrm_valid,

  // Upstream
  output logic [3:0]              ustrm_state,
  output logic [1:0]              ustrm_protid,
  output logic [`LPIF_DATA_W-1:0] ustrm_data,
  output logic                    ustrm_dvalid,
  output logic [`LPIF_CRC_W-1:0]  ustrm_crc,
  output logic                    ustrm_crc_valid,
  output logic                    ustrm_valid,

  // Debug counters
  output logic [`LPIF_CNT_W-1:0]  tx_downstream_debug_status,
  output logic [`LPIF_CNT_W-1:0]  rx_upstream_debug_status,

  // Online hold-off in cycles
  input  logic [7:0]              delay_x_value,
  input  logic [7:0]              delay_xz_value
);

  //////////////////////////////////////////////////////////////////////
  // Interconnect

  logic       tx_online_delay;
  logic       rx_online_delay;
  logic       tx_stb_bit;
  logic       tx_mrk_bit;
  lpif_word_u tx_word;
  lpif_word_u rx_word;
  logic       ustrm_valid_raw;

  //////////////////////////////////////////////////////////////////////
  // Instances

  lpif_auto_sync lpif_auto_sync_i (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_xz_value  (delay_xz_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_stb_bit      (tx_stb_bit),
    .tx_mrk_bit      (tx_mrk_bit)
  );

  lpif_name lpif_name_i (
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .rx_word         (rx_word),
    .tx_word         (tx_word),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid_raw (ustrm_valid_raw)
  );

  lpif_tx_stripe lpif_tx_stripe_i (
    .clk_wr                     (clk_wr),
    .rst                        (rst),
    .tx_word                    (tx_word),
    .tx_online_delay            (tx_online_delay),
    .tx_stb_bit                 (tx_stb_bit),
    .tx_mrk_bit                 (tx_mrk_bit),
    .tx_phy0                    (tx_phy0),
    .tx_phy1                    (tx_phy1),
    .tx_phy2                    (tx_phy2),
    .tx_phy3                    (tx_phy3),
    .tx_downstream_debug_status (tx_downstream_debug_status)
  );

  lpif_rx_destripe lpif_rx_destripe_i (
    .clk_wr                   (clk_wr),
    .rst                      (rst),
    .rx_phy0                  (rx_phy0),
    .rx_phy1                  (rx_phy1),
    .rx_phy2                  (rx_phy2),
    .rx_phy3                  (rx_phy3),
    .rx_online_delay          (rx_online_delay),
    .ustrm_valid_raw          (ustrm_valid_raw),
    .rx_word                  (rx_word),
    .ustrm_valid              (ustrm_valid),
    .rx_upstream_debug_status (rx_upstream_debug_status)
  );

endmodule

`default_nettype wire

// File: verif/lpif_assert.sv
// Bound checker for PHY quiet time, in-band bits, loopback fields and debug counters
`timescale 1ns/100ps
`include "lpif_cfg.svh"

`default_nettype none

module lpif_assert (
  input logic                    clk_wr,
  input logic                    rst,
  input logic                    tx_online,
  input logic                    rx_online,
  input logic [7:0]              delay_x_value,
  input logic [7:0]              delay_xz_value,
  input logic [`LPIF_PHY_W-1:0]  tx_phy0,
  input logic [`LPIF_PHY_W-1:0]  tx_phy1,
  input logic [`LPIF_PHY_W-1:0]  tx_phy2,
  input logic [`LPIF_PHY_W-1:0]  tx_phy3,
  input logic [`LPIF_PHY_W-1:0]  rx_phy0,
  input logic [3:0]              dstrm_state,
  input logic [1:0]              dstrm_protid,
  input logic [`LPIF_DATA_W-1:0] dstrm_data,
  input logic                    dstrm_dvalid,
  input logic [`LPIF_CRC_W-1:0]  dstrm_crc,
  input logic                    dstrm_crc_valid,
  input logic                    dstrm_valid,
  input logic [3:0]              ustrm_state,
  input logic [1:0]              ustrm_protid,
  input logic [`LPIF_DATA_W-1:0] ustrm_data,
  input logic                    ustrm_dvalid,
  input logic [`LPIF_CRC_W-1:0]  ustrm_crc,
  input logic                    ustrm_crc_valid,
  input logic                    ustrm_valid,
  input logic [`LPIF_CNT_W-1:0]  tx_downstream_debug_status,
  input logic [`LPIF_CNT_W-1:0]  rx_upstream_debug_status
);

  localparam int FLD_W = 80;

  logic [15:0]            tx_run;
  logic [15:0]            rx_run;
  logic [15:0]            tx_idx;
  logic                   exp_tx_on;
  logic                   exp_rx_on;
  logic                   exp_mrk;
  logic                   exp_stb;
  logic                   exp_valid;
  logic                   flip;
  logic [FLD_W-1:0]       dstrm_cat;
  logic [FLD_W-1:0]       ustrm_cat;
  logic [FLD_W-1:0]       dstrm_d1;
  logic [FLD_W-1:0]       dstrm_d2;
  logic                   valid_d1;
  logic                   valid_d2;
  logic                   tx_on_d1;
  logic                   rst_d1;
  logic [`LPIF_CNT_W-1:0] exp_tx_cnt;
  logic [`LPIF_CNT_W-1:0] exp_rx_cnt;

  //////////////////////////////////////////////////////////////////////
  // Reference model

  // Cycles in a row that online was sampled high
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_run <= '0;
      rx_run <= '0;
    end else begin
      tx_run <= !tx_online ? 16'd0 : (tx_run == 16'hffff) ? tx_run : tx_run + 16'd1;
      rx_run <= !rx_online ? 16'd0 : (rx_run == 16'hffff) ? rx_run : rx_run + 16'd1;
    end
  end

  assign exp_tx_on = tx_run >= {8'd0, delay_xz_value} + 16'd2;
  assign exp_rx_on = rx_run >= {8'd0, delay_x_value} + 16'd2;
  assign tx_idx    = tx_run - {8'd0, delay_xz_value} - 16'd2;
  assign exp_mrk   = ~tx_idx[0];
  assign exp_stb   = (tx_idx % `LPIF_STB_PERIOD) == 0;

  assign dstrm_cat = {dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid, dstrm_crc,
                      dstrm_crc_valid};
  assign ustrm_cat = {ustrm_state, ustrm_protid, ustrm_data, ustrm_dvalid, ustrm_crc,
                      ustrm_crc_valid};
  assign exp_valid = exp_rx_on & tx_on_d1 & valid_d2;

  // Marker inverted on the way back
  assign flip = rx_phy0[`LPIF_MRK_BIT] != tx_phy0[`LPIF_MRK_BIT];

  // Online words sent and markers flipped while rx is online
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      exp_tx_cnt <= '0;
      exp_rx_cnt <= '0;
    end else begin
      exp_tx_cnt <= exp_tx_cnt + exp_tx_on;
      exp_rx_cnt <= exp_rx_cnt + (flip & exp_rx_on);
    end
  end

  // History of the last two cycles
  always_ff @(posedge clk_wr) begin
    rst_d1    <= rst;
    dstrm_d1  <= dstrm_cat;
    dstrm_d2  <= dstrm_d1;
    valid_d1  <= dstrm_valid;
    valid_d2  <= valid_d1;
    tx_on_d1  <= exp_tx_on;
  end

  //////////////////////////////////////////////////////////////////////
  // Checks

  a_reset_cnt : assert property (@(posedge clk_wr) rst_d1 && !rst |->
      tx_downstream_debug_status == 0 && rx_upstream_debug_status == 0)
    else begin
      lpif_tb.err_cnt = lpif_tb.err_cnt + 1;
      $error("ERROR reset_cnt expected 0 actual %0d/%0d",
             $sampled(tx_downstream_debug_status), $sampled(rx_upstream_debug_status));
    end

  a_quiet : assert property (@(posedge clk_wr) disable iff (rst)
      !exp_tx_on |-> {tx_phy0, tx_phy1, tx_phy2, tx_phy3} == '0)
    else begin
      lpif_tb.err_cnt = lpif_tb.err_cnt + 1;
      $error("ERROR quiet_phy expected 0 actual %h",
             $sampled({tx_phy0, tx_phy1, tx_phy2, tx_phy3}));
    end

  a_ctrl : assert property (@(posedge clk_wr) disable iff (rst)
      exp_tx_on |-> tx_phy0[23:22] == {exp_stb, exp_mrk} &&
      {tx_phy1[23:22], tx_phy2[23:22], tx_phy3[23:22]} == '0)
    else begin
      lpif_tb.err_cnt = lpif_tb.err_cnt + 1;
      $error("ERROR stb_mrk expected %b actual %b",
             $sampled({exp_stb, exp_mrk}), $sampled(tx_phy0[23:22]));
    end

  a_fields : assert property (@(posedge clk_wr) disable iff (rst)
      tx_on_d1 |-> ustrm_cat == dstrm_d2)
    else begin
      lpif_tb.err_cnt = lpif_tb.err_cnt + 1;
      $error("ERROR loop_fields expected %h actual %h", $sampled(dstrm_d2),
             $sampled(ustrm_cat));
    end

  a_valid : assert property (@(posedge clk_wr) disable iff (rst) ustrm_valid == exp_valid)
    else begin
      lpif_tb.err_cnt = lpif_tb.err_cnt + 1;
      $error("ERROR ustrm_valid expected %b actual %b", $sampled(exp_valid),
             $sampled(ustrm_valid));
    end

  a_tx_cnt : assert property (@(posedge clk_wr) disable iff (rst)
      tx_downstream_debug_status == exp_tx_cnt)
    else begin
      lpif_tb.err_cnt = lpif_tb.err_cnt + 1;
      $error("ERROR tx_count expected %0d actual %0d", $sampled(exp_tx_cnt),
             $sampled(tx_downstream_debug_status));
    end

  // One error per flipped marker
  a_rx_cnt : assert property (@(posedge clk_wr) disable iff (rst)
      rx_upstream_debug_status == exp_rx_cnt)
    else begin
      lpif_tb.err_cnt = lpif_tb.err_cnt + 1;
      $error("ERROR marker_errors expected %0d actual %0d", $sampled(exp_rx_cnt),
             $sampled(rx_upstream_debug_status));
    end

endmodule

`default_nettype wire

// File: verif/lpif_tb.sv
// Testbench with loopback, marker fault injection, random stimulus and watchdog
`timescale 1ns/100ps
`include "lpif_cfg.svh"

`default_nettype none

module lpif_tb;

  localparam int RST_CYC  = 3;
  localparam int OFF_CYC  = 10;
  localparam int UP_CYC   = 60;
  localparam int FLIP_N   = 6;
  localparam int FLIP_GAP = 7;
  localparam int DROP_CYC = 10;
  localparam int TOTAL    = RST_CYC + OFF_CYC + 2 * UP_CYC + FLIP_N * FLIP_GAP + DROP_CYC;
  localparam int TIMEOUT  = (TOTAL + 50) * 20;

  // Bumped by the bound checker on every failed assertion
  int err_cnt = 0;

  logic                    clk_wr = 1'b0;
  logic                    rst;
  logic                    tx_online;
  logic                    rx_online;
  logic                    flip_mrk;
  logic [7:0]              delay_x_value;
  logic [7:0]              delay_xz_value;
  logic [`LPIF_PHY_W-1:0]  tx_phy0, tx_phy1, tx_phy2, tx_phy3;
  logic [`LPIF_PHY_W-1:0]  rx_phy0, rx_phy1, rx_phy2, rx_phy3;
  logic [3:0]              dstrm_state, ustrm_state;
  logic [1:0]              dstrm_protid, ustrm_protid;
  logic [`LPIF_DATA_W-1:0] dstrm_data, ustrm_data;
  logic                    dstrm_dvalid, ustrm_dvalid;
  logic [`LPIF_CRC_W-1:0]  dstrm_crc, ustrm_crc;
  logic                    dstrm_crc_valid, ustrm_crc_valid;
  logic                    dstrm_valid, ustrm_valid;
  logic [`LPIF_CNT_W-1:0]  tx_downstream_debug_status;
  logic [`LPIF_CNT_W-1:0]  rx_upstream_debug_status;

  always #10 clk_wr = ~clk_wr;

  //////////////////////////////////////////////////////////////////////
  // Loopback with the marker inverted on demand

  assign rx_phy0 = tx_phy0 ^ ({{(`LPIF_PHY_W-1){1'b0}}, flip_mrk} << `LPIF_MRK_BIT);
  assign rx_phy1 = tx_phy1;
  assign rx_phy2 = tx_phy2;
  assign rx_phy3 = tx_phy3;

  lpif_top lpif_top_i (.*);

  bind lpif_top lpif_assert lpif_assert_i (.*);

  //////////////////////////////////////////////////////////////////////
  // Stimulus

  task automatic randomize_fields();
    dstrm_state     = 4'($urandom);
    dstrm_protid    = 2'($urandom);
    dstrm_data      = {$urandom, $urandom};
    dstrm_dvalid    = 1'($urandom);
    dstrm_crc       = 8'($urandom);
    dstrm_crc_valid = 1'($urandom);
    dstrm_valid     = 1'($urandom);
  endtask

  // New fields on every falling edge
  task automatic run_cycles(input int n);
    repeat (n) begin
      @(negedge clk_wr);
      randomize_fields();
    end
  endtask

  initial begin
    void'($urandom(32'h11e4_596a));
    rst            = 1'b1;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    flip_mrk       = 1'b0;
    delay_x_value  = 8'd7;
    delay_xz_value = 8'd5;
    randomize_fields();
    repeat (RST_CYC) @(posedge clk_wr);
    @(negedge clk_wr);
    rst = 1'b0;
    run_cycles(OFF_CYC);
    tx_online = 1'b1;
    rx_online = 1'b1;
    run_cycles(UP_CYC);
    // Single marker flips well after lock
    repeat (FLIP_N) begin
      flip_mrk = 1'b1;
      run_cycles(1);
      flip_mrk = 1'b0;
      run_cycles(FLIP_GAP - 1);
    end
    tx_online = 1'b0;
    rx_online = 1'b0;
    run_cycles(DROP_CYC);
    tx_online = 1'b1;
    rx_online = 1'b1;
    run_cycles(UP_CYC);
    if (err_cnt == 0) begin
      $display("No errors");
      $finish;
    end else begin
      $display("Errors found");
      $fatal(1, "%0d checks failed", err_cnt);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // First error and watchdog

  always @(posedge clk_wr) begin
    if (err_cnt != 0) begin
      $display("Errors found");
      $fatal(1, "a check failed, stopping at first error");
    end
  end

  initial begin
    #(TIMEOUT);
    $display("Errors found");
    $fatal(1, "timeout, the test sequence did not finish in time");
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+verilog
verilog/lpif_pkg.sv
verilog/lpif_auto_sync.sv
verilog/lpif_name.sv
verilog/lpif_tx_stripe.sv
verilog/lpif_rx_destripe.sv
verilog/lpif_top.sv
verif/lpif_assert.sv
verif/lpif_tb.sv

// File: Makefile
# Verilator build and run for the link endpoint testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module lpif_tb \
	  -f files.f -o lpif_sim

run: compile
	./obj_dir/lpif_sim +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	@if grep -q "Errors found" sim.log; then echo "FAIL"; exit 1; fi
	@if ! grep -q "No errors" sim.log; then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir sim.log
